//--- lsu_top.f
rtl/lsu_pkg.sv
rtl/lsu_ctrl.sv
rtl/lsu_perf_counter.sv
rtl/lsu_store_align.sv
rtl/lsu_load_extract.sv
rtl/lsu_top.sv
test/tb_clock_gen.sv
test/lsu_checker.sv
test/lsu_tb.sv

//--- test/lsu_tb.sv
module lsu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clock, rst_n, start, busy, done;
	logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;
	logic [63:0] rdata;
	logic [1:0] rresp, bresp, cur_resp;
	lsu_pkg::mem_req_t req;
	lsu_pkg::mem_result_t result;
	lsu_pkg::perf_t perf;
	lsu_pkg::axi_addr_t ar, aw;
	lsu_pkg::axi_wdata_t w;
	lsu_pkg::axi_addr_t seen; // address beat taken by the memory model

	logic [63:0] mem [logic [28:0]]; // sparse beat memory
	string row_name [0:39];
	lsu_pkg::inst_u row_inst [0:39];
	logic [31:0] row_src1 [0:39];
	logic [31:0] row_src2 [0:39];
	logic [1:0] row_resp [0:39];
	logic [63:0] row_exp [0:39];
	int n_rows, errors, n_cycles;

	tb_clock_gen clk0 (.clock(clock), .rst_n(rst_n));

	lsu_top dut0 (.*);

	always @(posedge clock)
		if (rst_n)
			n_cycles++; // cycles since reset release

	function automatic logic [63:0] fill_beat(input logic [31:0] addr);
		logic [31:0] base;
		base = {addr[31:3], 3'b000};
		return {~base, base};
	endfunction

	function automatic lsu_pkg::inst_u load_inst(input logic [2:0] f3, input logic [4:0] rd,
			input logic [11:0] imm);
		lsu_pkg::inst_u u;
		u.i = {imm, 5'd1, f3, rd, lsu_pkg::opcode_load};
		return u;
	endfunction

	function automatic lsu_pkg::inst_u store_inst(input logic [2:0] f3, input logic [11:0] imm);
		lsu_pkg::inst_u u;
		u.s = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], lsu_pkg::opcode_store};
		return u;
	endfunction

	// beat seen in memory after storing nbytes of data at addr
	function automatic logic [63:0] store_result(input logic [31:0] addr, input logic [31:0] data,
			input int nbytes);
		logic [63:0] beat;
		int j;
		beat = fill_beat(addr);
		for (j = 0; j < nbytes; j++)
			beat[(addr[2:0] + j) * 8 +: 8] = data[j * 8 +: 8];
		return beat;
	endfunction

	task automatic add_row(input string name, input lsu_pkg::inst_u inst, input logic [31:0] s1,
			input logic [31:0] s2, input logic [1:0] resp, input logic [63:0] exp);
		row_name[n_rows] = name;
		row_inst[n_rows] = inst;
		row_src1[n_rows] = s1;
		row_src2[n_rows] = s2;
		row_resp[n_rows] = resp;
		row_exp[n_rows] = exp;
		n_rows++;
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
		errors++;
		$display("Mismatch %s: expected %h, actual %h", name, exp, act);
	endtask

	task automatic wait_ready(input logic for_read, input string what);
		int c;
		logic got;
		c = 0;
		got = 0;
		while (!got && c < 200) begin
			@(negedge clock);
			got = for_read ? rready : bready;
			c++;
		end
		if (!got) begin
			errors++;
			$display("slice never raised %s", what);
		end
	endtask

	task automatic serve_read();
		lsu_pkg::axi_addr_t a;
		logic [63:0] beat;
		int d, c;
		logic got;
		d = $urandom % 4;
		c = 0;
		got = 0;
		while (!got && c < 200) begin
			@(posedge clock);
			#1 arready = c >= d; // random address stall
			@(negedge clock);
			if (arvalid && arready) begin
				got = 1;
				a = ar;
			end
			c++;
		end
		@(posedge clock);
		#1 arready = 1'b0;
		if (!got) begin
			errors++;
			$display("read address handshake never completed");
			return;
		end
		seen = a;
		beat = mem.exists(a.addr[31:3]) ? mem[a.addr[31:3]] : fill_beat(a.addr);
		if (a.addr >= lsu_pkg::narrow_base && a.addr < lsu_pkg::narrow_limit && a.addr[2])
			beat = {32'd0, beat[63:32]}; // narrow slave returns its word on the low lanes
		repeat ($urandom % 3) @(posedge clock);
		@(posedge clock);
		#1;
		rdata = beat;
		rresp = cur_resp;
		rvalid = 1'b1;
		wait_ready(1'b1, "rready");
		@(posedge clock);
		#1 rvalid = 1'b0;
	endtask

	task automatic serve_write();
		lsu_pkg::axi_addr_t a;
		lsu_pkg::axi_wdata_t wd;
		logic [63:0] beat;
		int da, dw, c, b;
		logic got_a, got_w;
		da = $urandom % 4;
		dw = $urandom % 4;
		c = 0;
		got_a = 0;
		got_w = 0;
		while (!(got_a && got_w) && c < 200) begin
			@(posedge clock);
			#1;
			awready = !got_a && c >= da;
			wready = !got_w && c >= dw;
			@(negedge clock);
			if (awvalid && awready) begin
				got_a = 1;
				a = aw;
			end
			if (wvalid && wready) begin
				got_w = 1;
				wd = w;
			end
			c++;
		end
		@(posedge clock);
		#1;
		awready = 1'b0;
		wready = 1'b0;
		if (!(got_a && got_w)) begin
			errors++;
			$display("write address or data handshake never completed");
			return;
		end
		seen = a;
		beat = mem.exists(a.addr[31:3]) ? mem[a.addr[31:3]] : fill_beat(a.addr);
		for (b = 0; b < 8; b++)
			if (wd.strb[b])
				beat[b * 8 +: 8] = wd.data[b * 8 +: 8];
		mem[a.addr[31:3]] = beat;
		repeat ($urandom % 3) @(posedge clock);
		@(posedge clock);
		#1;
		bresp = cur_resp;
		bvalid = 1'b1;
		wait_ready(1'b0, "bready");
		@(posedge clock);
		#1 bvalid = 1'b0;
	endtask

	task automatic run_row(input int i);
		logic [31:0] addr;
		logic [63:0] beat;
		logic got, is_load;
		int k;
		is_load = row_inst[i].i.opcode == lsu_pkg::opcode_load;
		cur_resp = row_resp[i];
		seen = 'x;
		@(posedge clock);
		#1;
		req = {row_inst[i], row_src1[i], row_src2[i]};
		start = 1'b1;
		@(posedge clock);
		#1 req = {store_inst(lsu_pkg::f3_w, 12'd0), 32'h0000_7000, 32'hdead_beef}; // while busy
		@(posedge clock);
		#1 start = 1'b0;
		k = 0;
		got = 0;
		while (!got && k < 200) begin
			@(negedge clock);
			got = done;
			k++;
		end
		if (!got) begin
			errors++;
			$display("no done for %s within 200 cycles", row_name[i]);
			return;
		end
		if (result.err !== (row_resp[i] != 2'd0))
			report_mismatch({row_name[i], " err"}, row_resp[i] != 2'd0, result.err);
		if (result.is_load !== is_load)
			report_mismatch({row_name[i], " is_load"}, is_load, result.is_load);
		// funct3[1:0] is log2 of the access width in bytes
		if (seen.size !== {1'b0, row_inst[i].i.funct3[1:0]})
			report_mismatch({row_name[i], " size"}, row_inst[i].i.funct3[1:0], seen.size);
		if (is_load) begin
			if (result.value !== row_exp[i][31:0])
				report_mismatch(row_name[i], row_exp[i][31:0], result.value);
			if (result.rd !== row_inst[i].i.rd)
				report_mismatch({row_name[i], " rd"}, row_inst[i].i.rd, result.rd);
		end else if (row_resp[i] == 2'd0) begin
			addr = row_src1[i] + {{20{row_inst[i].s.imm_hi[6]}}, row_inst[i].s.imm_hi,
				row_inst[i].s.imm_lo};
			beat = mem.exists(addr[31:3]) ? mem[addr[31:3]] : fill_beat(addr);
			if (beat !== row_exp[i])
				report_mismatch(row_name[i], row_exp[i], beat);
		end else if (result.value !== 32'd0) begin
			report_mismatch({row_name[i], " value"}, 0, result.value);
		end
		@(negedge clock);
		if (busy || done) begin
			errors++;
			$display("%s: slice busy again after done, a start while busy was taken", row_name[i]);
		end
	endtask

	initial begin
		int wd, off, s, k, n_load, n_store, n_err;
		logic [2:0] f3;
		logic [31:0] base;
		void'($urandom(32'h53eb));
		start = 1'b0;
		req = '0;
		arready = 1'b0;
		rdata = '0;
		rresp = 2'd0;
		rvalid = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bresp = 2'd0;
		bvalid = 1'b0;
		cur_resp = 2'd0;
		errors = 0;
		n_rows = 0;
		n_cycles = 0;
		s = 0;
		// stores at every aligned offset, one fresh beat each
		for (wd = 0; wd < 3; wd++) begin
			f3 = (wd == 0) ? lsu_pkg::f3_b : (wd == 1) ? lsu_pkg::f3_h : lsu_pkg::f3_w;
			for (off = 0; off < 8; off += 1 << wd) begin
				base = 32'h0000_4000 + 32'(s * 8);
				add_row($sformatf("s%0d_off%0d", 8 << wd, off), store_inst(f3, 12'(off)), base,
					32'hc3b2_a190, 2'd0, store_result(base + off, 32'hc3b2_a190, 1 << wd));
				s++;
			end
		end
		add_row("sw_neg", store_inst(lsu_pkg::f3_w, 12'hff8), 32'h0000_5010, 32'h1234_5678, 2'd0,
			64'hffff_aff7_1234_5678);
		// wide beat at 0x0012_3480 is ffed_cb7f_0012_3480
		add_row("lb_w0", load_inst(lsu_pkg::f3_b, 5'd5, 12'd0), 32'h0012_3480, 0, 0, 32'hffff_ff80);
		add_row("lbu_w0", load_inst(lsu_pkg::f3_bu, 5'd6, 12'd0), 32'h0012_3480, 0, 0, 32'h80);
		add_row("lb_w5", load_inst(lsu_pkg::f3_b, 5'd7, 12'd5), 32'h0012_3480, 0, 0, 32'hffff_ffcb);
		add_row("lh_w6", load_inst(lsu_pkg::f3_h, 5'd8, 12'd6), 32'h0012_3480, 0, 0, 32'hffff_ffed);
		add_row("lhu_w6", load_inst(lsu_pkg::f3_hu, 5'd10, 12'd6), 32'h0012_3480, 0, 0, 32'hffed);
		add_row("lw_w4", load_inst(lsu_pkg::f3_w, 5'd11, 12'd4), 32'h0012_3480, 0, 0, 32'hffed_cb7f);
		add_row("lw_neg", load_inst(lsu_pkg::f3_w, 5'd12, 12'hff4), 32'h0012_3490, 0, 0, 32'hffed_cb7f);
		// narrow beat at 0x8765_4320 is 789a_bcdf_8765_4320
		add_row("lw_n4", load_inst(lsu_pkg::f3_w, 5'd13, 12'd4), 32'h8765_4320, 0, 0, 32'h789a_bcdf);
		add_row("lw_n0", load_inst(lsu_pkg::f3_w, 5'd14, 12'd0), 32'h8765_4320, 0, 0, 32'h8765_4320);
		add_row("lbu_n5", load_inst(lsu_pkg::f3_bu, 5'd15, 12'd5), 32'h8765_4320, 0, 0, 32'hbc);
		add_row("lb_n3", load_inst(lsu_pkg::f3_b, 5'd16, 12'd3), 32'h8765_4320, 0, 0, 32'hffff_ff87);
		add_row("lh_n6", load_inst(lsu_pkg::f3_h, 5'd17, 12'd6), 32'h8765_4320, 0, 0, 32'h789a);
		add_row("lhu_n2", load_inst(lsu_pkg::f3_hu, 5'd18, 12'd2), 32'h8765_4320, 0, 0, 32'h8765);
		add_row("lh_n2", load_inst(lsu_pkg::f3_h, 5'd19, 12'd2), 32'h8765_4320, 0, 0, 32'hffff_8765);
		add_row("lw_rerr", load_inst(lsu_pkg::f3_w, 5'd9, 12'd0), 32'h0012_3480, 0, 2'd2, 0);
		add_row("sb_berr", store_inst(lsu_pkg::f3_b, 12'd1), 32'h0000_4800, 32'h55, 2'd3, 0);

		fork
			forever begin
				@(negedge clock);
				if (arvalid)
					serve_read();
				else if (awvalid || wvalid)
					serve_write();
			end
		join_none

		k = 0;
		while (!rst_n && k < 50) begin
			@(posedge clock);
			k++;
		end
		if (!rst_n) begin
			errors++;
			$display("reset never released");
		end
		@(negedge clock);
		if (busy || done || arvalid || awvalid || wvalid || rready || bready) begin
			errors++;
			$display("control outputs not low after reset");
		end
		if (perf.loads !== 0 || perf.stores !== 0 || perf.errors !== 0)
			report_mismatch("perf after reset", 0, {perf.loads[15:0], perf.stores[15:0]});

		n_load = 0;
		n_store = 0;
		n_err = 0;
		for (k = 0; k < n_rows; k++) begin
			run_row(k);
			if (row_inst[k].i.opcode == lsu_pkg::opcode_load)
				n_load++;
			else
				n_store++;
			if (row_resp[k] != 2'd0)
				n_err++;
		end

		@(negedge clock);
		if (perf.loads !== n_load)
			report_mismatch("perf.loads", n_load, perf.loads);
		if (perf.stores !== n_store)
			report_mismatch("perf.stores", n_store, perf.stores);
		if (perf.errors !== n_err)
			report_mismatch("perf.errors", n_err, perf.errors);
		if (perf.cycles !== n_cycles)
			report_mismatch("perf.cycles", n_cycles, perf.cycles);
		if (mem.exists(29'h0e00)) begin // beat of 0x0000_7000
			errors++;
			$display("store issued while busy reached memory");
		end

		$display("%0d errors over %0d rows", errors, n_rows);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- test/lsu_checker.sv
module lsu_checker (
	input logic                clock,
	input logic                rst_n,
	input lsu_pkg::axi_addr_t  ar,
	input logic                arvalid,
	input logic                arready,
	input lsu_pkg::axi_addr_t  aw,
	input logic                awvalid,
	input logic                awready,
	input lsu_pkg::axi_wdata_t w,
	input logic                wvalid,
	input logic                wready,
	input logic                done
);
	timeunit 1ns;
	timeprecision 100ps;

	ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(ar))
		else $error("read address dropped or changed before arready");

	aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(aw))
		else $error("write address dropped or changed before awready");

	w_hold: assert property (@(posedge clock) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(w))
		else $error("write data dropped or changed before wready");

	done_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		done |=> !done)
		else $error("done held for more than one cycle");

	one_kind: assert property (@(posedge clock) disable iff (!rst_n)
		!(arvalid && awvalid))
		else $error("read and write address valid together");

	reset_quiet: assert property (@(posedge clock)
		!rst_n |-> !arvalid && !awvalid && !wvalid)
		else $error("bus valid raised during reset");

endmodule

bind lsu_top lsu_checker chk0 (
	.clock   (clock),
	.rst_n   (rst_n),
	.ar      (ar),
	.arvalid (arvalid),
	.arready (arready),
	.aw      (aw),
	.awvalid (awvalid),
	.awready (awready),
	.w       (w),
	.wvalid  (wvalid),
	.wready  (wready),
	.done    (done)
);

//--- test/tb_clock_gen.sv
module tb_clock_gen (
	output logic clock,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clock);
		#1 rst_n = 1'b1;
	end

endmodule

//--- rtl/lsu_top.sv
module lsu_top (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 start,
	input  lsu_pkg::mem_req_t    req,
	output logic                 busy,
	output logic                 done,
	output lsu_pkg::mem_result_t result,
	output lsu_pkg::perf_t       perf,
	output lsu_pkg::axi_addr_t   ar,
	output logic                 arvalid,
	input  logic                 arready,
	input  logic [63:0]          rdata,
	input  logic [1:0]           rresp,
	input  logic                 rvalid,
	output logic                 rready,
	output lsu_pkg::axi_addr_t   aw,
	output logic                 awvalid,
	input  logic                 awready,
	output lsu_pkg::axi_wdata_t  w,
	output logic                 wvalid,
	input  logic                 wready,
	input  logic [1:0]           bresp,
	input  logic                 bvalid,
	output logic                 bready
);

	lsu_pkg::mem_req_t cur_req;
	logic [31:0]       load_value;
	logic              load_done;
	logic              store_done;
	logic              err_done;

	lsu_ctrl ctrl0 (
		.clock      (clock),
		.rst_n      (rst_n),
		.start      (start),
		.req        (req),
		.busy       (busy),
		.done       (done),
		.result     (result),
		.cur_req    (cur_req),
		.load_value (load_value),
		.arvalid    (arvalid),
		.arready    (arready),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.awvalid    (awvalid),
		.awready    (awready),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.load_done  (load_done),
		.store_done (store_done),
		.err_done   (err_done)
	);

	lsu_store_align align0 (
		.cur_req (cur_req),
		.ar      (ar),
		.aw      (aw),
		.w       (w)
	);

	lsu_load_extract extract0 (
		.rdata  (rdata),
		.addr   (ar.addr), // read address of the request in flight
		.funct3 (cur_req.inst.i.funct3),
		.value  (load_value)
	);

	lsu_perf_counter perf0 (
		.clock      (clock),
		.rst_n      (rst_n),
		.load_done  (load_done),
		.store_done (store_done),
		.err_done   (err_done),
		.perf       (perf)
	);

endmodule

//--- rtl/lsu_load_extract.sv
module lsu_load_extract (
	input  logic [63:0] rdata,
	input  logic [31:0] addr,
	input  logic [2:0]  funct3,
	output logic [31:0] value
);

	logic        narrow;
	logic [2:0]  offset;
	logic [63:0] shifted;

	// 32-bit lane window only shifts within the low word pair
	assign narrow = addr >= lsu_pkg::narrow_base && addr < lsu_pkg::narrow_limit;
	assign offset = narrow ? {1'b0, addr[1:0]} : addr[2:0];

	assign shifted = rdata >> {offset, 3'b000};

	always_comb begin
		case (funct3)
			lsu_pkg::f3_b: begin
				value = {{24{shifted[7]}}, shifted[7:0]};
			end
			lsu_pkg::f3_h: begin
				value = {{16{shifted[15]}}, shifted[15:0]};
			end
			lsu_pkg::f3_w: begin
				value = shifted[31:0];
			end
			lsu_pkg::f3_bu: begin
				value = {24'd0, shifted[7:0]};
			end
			lsu_pkg::f3_hu: begin
				value = {16'd0, shifted[15:0]};
			end
			default: begin
				value = 32'd0; // not a load width
			end
		endcase
	end

endmodule

//--- rtl/lsu_store_align.sv
module lsu_store_align (
	input  lsu_pkg::mem_req_t   cur_req,
	output lsu_pkg::axi_addr_t  ar,
	output lsu_pkg::axi_addr_t  aw,
	output lsu_pkg::axi_wdata_t w
);

	logic [31:0] imm;
	logic [31:0] addr;
	logic [2:0]  size;
	logic [7:0]  mask;

	always_comb begin
		if (cur_req.inst.s.opcode == lsu_pkg::opcode_store)
			imm = {{20{cur_req.inst.s.imm_hi[6]}}, cur_req.inst.s.imm_hi, cur_req.inst.s.imm_lo};
		else
			imm = {{20{cur_req.inst.i.imm[11]}}, cur_req.inst.i.imm};
	end

	assign addr = cur_req.src1 + imm;

	always_comb begin
		case (cur_req.inst.i.funct3)
			lsu_pkg::f3_b, lsu_pkg::f3_bu: begin
				size = 3'd0;
				mask = 8'h01;
			end
			lsu_pkg::f3_h, lsu_pkg::f3_hu: begin
				size = 3'd1;
				mask = 8'h03;
			end
			default: begin
				size = 3'd2;
				mask = 8'h0f;
			end
		endcase
	end

	assign ar.addr = addr;
	assign ar.size = size;
	assign aw.addr = addr;
	assign aw.size = size;

	// lane placement on the 64-bit beat
	assign w.data = {32'd0, cur_req.src2} << {addr[2:0], 3'b000};
	assign w.strb = mask << addr[2:0];

endmodule

//--- rtl/lsu_perf_counter.sv
module lsu_perf_counter (
	input  logic           clock,
	input  logic           rst_n,
	input  logic           load_done,
	input  logic           store_done,
	input  logic           err_done,
	output lsu_pkg::perf_t perf
);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			perf <= '0;
		end else begin
			perf.cycles <= perf.cycles + 32'd1; // free running since reset
			if (load_done)
				perf.loads <= perf.loads + 32'd1;
			if (store_done)
				perf.stores <= perf.stores + 32'd1;
			if (err_done)
				perf.errors <= perf.errors + 32'd1; // also counted as load or store
		end
	end

endmodule

//--- rtl/lsu_ctrl.sv
module lsu_ctrl (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 start,
	input  lsu_pkg::mem_req_t    req,
	output logic                 busy,
	output logic                 done,
	output lsu_pkg::mem_result_t result,
	output lsu_pkg::mem_req_t    cur_req,
	input  logic [31:0]          load_value,
	output logic                 arvalid,
	input  logic                 arready,
	input  logic [1:0]           rresp,
	input  logic                 rvalid,
	output logic                 rready,
	output logic                 awvalid,
	input  logic                 awready,
	output logic                 wvalid,
	input  logic                 wready,
	input  logic [1:0]           bresp,
	input  logic                 bvalid,
	output logic                 bready,
	output logic                 load_done,
	output logic                 store_done,
	output logic                 err_done
);

	logic [1:0] state;
	logic       aw_done; // write address already accepted
	logic       w_done;
	logic       is_load;
	logic       take;
	logic       ar_fire;
	logic       aw_fire;
	logic       w_fire;
	logic       r_fire;
	logic       b_fire;

	assign is_load = cur_req.inst.i.opcode == lsu_pkg::opcode_load;
	assign take    = start && state == lsu_pkg::st_idle;
	assign ar_fire = arvalid & arready;
	assign aw_fire = awvalid & awready;
	assign w_fire  = wvalid & wready;
	assign r_fire  = rvalid & rready;
	assign b_fire  = bvalid & bready;

	assign busy   = state != lsu_pkg::st_idle;
	assign done   = state == lsu_pkg::st_finish;
	assign rready = state == lsu_pkg::st_wait && is_load;
	assign bready = state == lsu_pkg::st_wait && !is_load;

	assign load_done  = done & result.is_load;
	assign store_done = done & ~result.is_load;
	assign err_done   = done & result.err;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state   <= lsu_pkg::st_idle;
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else begin
			case (state)
				lsu_pkg::st_idle: begin
					if (start) begin
						state   <= lsu_pkg::st_request;
						arvalid <= req.inst.i.opcode == lsu_pkg::opcode_load;
						awvalid <= req.inst.i.opcode != lsu_pkg::opcode_load;
						wvalid  <= req.inst.i.opcode != lsu_pkg::opcode_load;
						aw_done <= 1'b0;
						w_done  <= 1'b0;
					end
				end
				lsu_pkg::st_request: begin
					if (ar_fire)
						arvalid <= 1'b0;
					if (aw_fire) begin
						awvalid <= 1'b0;
						aw_done <= 1'b1;
					end
					if (w_fire) begin
						wvalid <= 1'b0;
						w_done <= 1'b1;
					end
					// channels may complete in either order
					if (is_load ? ar_fire : ((aw_done | aw_fire) & (w_done | w_fire)))
						state <= lsu_pkg::st_wait;
				end
				lsu_pkg::st_wait: begin
					if (r_fire | b_fire)
						state <= lsu_pkg::st_finish;
				end
				default: state <= lsu_pkg::st_idle; // finish lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (take)
			cur_req <= req;
		if (r_fire) begin
			result.rd      <= cur_req.inst.i.rd;
			result.value   <= (rresp == 2'b00) ? load_value : 32'd0;
			result.is_load <= 1'b1;
			result.err     <= |rresp;
		end
		if (b_fire) begin
			result.rd      <= cur_req.inst.i.rd;
			result.value   <= 32'd0;
			result.is_load <= 1'b0;
			result.err     <= |bresp;
		end
	end

endmodule

//--- rtl/lsu_pkg.sv
package lsu_pkg;

	localparam logic [6:0] opcode_load  = 7'd3;
	localparam logic [6:0] opcode_store = 7'd35;

	localparam logic [2:0] f3_b  = 3'b000;
	localparam logic [2:0] f3_h  = 3'b001;
	localparam logic [2:0] f3_w  = 3'b010;
	localparam logic [2:0] f3_bu = 3'b100;
	localparam logic [2:0] f3_hu = 3'b101;

	localparam logic [31:0] narrow_base  = 32'h8000_0000; // 32-bit lane window
	localparam logic [31:0] narrow_limit = 32'hC000_0000;

	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_request = 2'd1;
	localparam logic [1:0] st_wait    = 2'd2;
	localparam logic [1:0] st_finish  = 2'd3;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} itype_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} stype_t;

	// loads read the word as I-format, stores as S-format
	typedef union packed {
		itype_t i;
		stype_t s;
	} inst_u;

	typedef struct packed {
		inst_u       inst;
		logic [31:0] src1;
		logic [31:0] src2;
	} mem_req_t;

	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] value;
		logic        is_load;
		logic        err;
	} mem_result_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} axi_addr_t;

	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  strb;
	} axi_wdata_t;

	typedef struct packed {
		logic [31:0] cycles;
		logic [31:0] loads;
		logic [31:0] stores;
		logic [31:0] errors;
	} perf_t;

endpackage
